// ==== c16_defines.svh ====
`ifndef C16_DEFINES_SVH
`define C16_DEFINES_SVH

////////////////////////////////////////
// Datapath and register file
////////////////////////////////////////
`define C16_XLEN      16
`define C16_NREGS     8
`define C16_REG_W     3

////////////////////////////////////////
// Renaming and stations
////////////////////////////////////////
`define C16_ROB_DEPTH 8
`define C16_TAG_W     3  // Tag is a reorder slot index
`define C16_RS_SLOTS  4

// Opcodes in the top five bits of a word
`define C16_OPC_ADDI  5'd0
`define C16_OPC_ADD   5'd1
`define C16_OPC_SUBI  5'd2
`define C16_OPC_SUB   5'd3

`endif

// ==== c16_pkg.sv ====
`default_nettype none
`include "c16_defines.svh"

package c16_pkg;

	// Immediate form with a signed imm
	typedef struct packed {
		logic [4:0]            opcode;
		logic [`C16_REG_W-1:0] dest;
		logic [`C16_REG_W-1:0] src_a;
		logic signed [4:0]     imm;
	} imm_form_t;

	typedef struct packed {
		logic [4:0]            opcode;
		logic [`C16_REG_W-1:0] dest;
		logic [`C16_REG_W-1:0] src_a;
		logic [1:0]            unused;
		logic [`C16_REG_W-1:0] src_b;
	} reg_form_t;

	typedef union packed {
		imm_form_t imm_form;
		reg_form_t reg_form;
	} instr_u;

	typedef enum logic {
		ALU_ADD = 1'b0,
		ALU_SUB = 1'b1
	} alu_op_e;

	typedef struct packed {
		logic                  ready;
		logic [`C16_TAG_W-1:0] tag;
		logic [`C16_XLEN-1:0]  value;  // Valid once ready
	} operand_t;

	typedef struct packed {
		logic                  valid;
		logic [`C16_TAG_W-1:0] tag;
		alu_op_e               op;
		logic [`C16_REG_W-1:0] dest;
		operand_t              a;
		operand_t              b;
	} issue_pkt_t;

	// One result broadcast bus
	typedef struct packed {
		logic                  valid;
		logic [`C16_TAG_W-1:0] tag;
		logic [`C16_REG_W-1:0] dest;
		logic [`C16_XLEN-1:0]  value;
	} result_t;

	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [2:0]           adr;
		logic [`C16_XLEN-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                 ack;
		logic [`C16_XLEN-1:0] dat;
	} wb_rsp_t;

	// Pick up a broadcast value for an operand still waiting on its tag
	function automatic operand_t snoop(operand_t op, result_t bus_a, result_t bus_b);
		operand_t o;
		o = op;
		if (!op.ready && bus_a.valid && bus_a.tag == op.tag) begin
			o.ready = 1'b1;
			o.value = bus_a.value;
		end
		if (!op.ready && bus_b.valid && bus_b.tag == op.tag) begin
			o.ready = 1'b1;
			o.value = bus_b.value;
		end
		return o;
	endfunction

endpackage

`default_nettype wire

// ==== c16_issue.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "c16_defines.svh"

module c16_issue import c16_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	input  result_t    res0,
	input  result_t    res1,
	input  logic       rs0_full,
	input  logic       rs1_full,
	input  logic       rob_full,
	input  logic [`C16_NREGS-1:0][`C16_XLEN-1:0] committed,
	output issue_pkt_t lane0_pkt,
	output issue_pkt_t lane1_pkt,
	output result_t    alloc
);

	logic                  wb_cycle;
	logic                  wr_instr;
	logic                  known;
	logic                  room;
	logic                  take;
	logic                  ack_q;
	logic [`C16_XLEN-1:0]  rd_dat;
	logic                  iss_pend;  // Held word issues this cycle
	logic [`C16_XLEN-1:0]  iss_word;
	logic [`C16_TAG_W-1:0] tag_cnt;
	logic [`C16_XLEN-1:0]  imm_ext;
	logic                  use_src_b;
	instr_u                req_word;
	instr_u                instr;
	issue_pkt_t            pkt;
	operand_t              rat [`C16_NREGS];  // In-flight table of values or pending tags

	////////////////////////////////////////
	// Wishbone slave
	////////////////////////////////////////
	assign req_word = wb_req.dat;
	assign wb_cycle = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_instr = wb_req.we && wb_req.adr == 3'd0;
	assign known = req_word.imm_form.opcode inside
		{`C16_OPC_ADDI, `C16_OPC_ADD, `C16_OPC_SUBI, `C16_OPC_SUB};
	assign room = !rob_full && !(tag_cnt[0] ? rs1_full : rs0_full);
	assign take = wb_cycle && (!(wr_instr && known) || room);  // Back-pressure on issue only
	assign wb_rsp = '{ack: ack_q, dat: rd_dat};

	always_ff @(posedge clk) begin
		if (take) begin
			iss_word <= wb_req.dat;
			rd_dat <= committed[wb_req.adr];
		end
	end

	////////////////////////////////////////
	// Decode and rename
	////////////////////////////////////////
	assign instr = iss_word;
	assign imm_ext = {{(`C16_XLEN-5){instr.imm_form.imm[4]}}, instr.imm_form.imm};

	always_comb begin
		pkt.valid = iss_pend;
		pkt.tag = tag_cnt;
		pkt.dest = instr.imm_form.dest;
		case (instr.imm_form.opcode)
			`C16_OPC_ADD: begin
				pkt.op = ALU_ADD;
				use_src_b = 1'b1;
			end
			`C16_OPC_SUBI: begin
				pkt.op = ALU_SUB;
				use_src_b = 1'b0;
			end
			`C16_OPC_SUB: begin
				pkt.op = ALU_SUB;
				use_src_b = 1'b1;
			end
			default: begin
				pkt.op = ALU_ADD;
				use_src_b = 1'b0;
			end
		endcase
		pkt.a = snoop(rat[instr.imm_form.src_a], res0, res1);  // Forward same-cycle results
		if (use_src_b)
			pkt.b = snoop(rat[instr.reg_form.src_b], res0, res1);
		else
			pkt.b = '{ready: 1'b1, tag: '0, value: imm_ext};
	end

	// Steer by low tag bit
	always_comb begin
		lane0_pkt = pkt;
		lane1_pkt = pkt;
		lane0_pkt.valid = pkt.valid && !tag_cnt[0];
		lane1_pkt.valid = pkt.valid && tag_cnt[0];
	end

	assign alloc = '{valid: iss_pend, tag: tag_cnt, dest: instr.imm_form.dest, value: '0};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
			iss_pend <= 1'b0;
			tag_cnt <= '0;
			for (int i = 0; i < `C16_NREGS; i++)
				rat[i] <= '{ready: 1'b1, tag: '0, value: '0};
		end else begin
			ack_q <= take;
			iss_pend <= take && wr_instr && known;  // Unknown opcodes dropped here
			for (int i = 0; i < `C16_NREGS; i++)
				rat[i] <= snoop(rat[i], res0, res1);
			if (iss_pend) begin
				rat[instr.imm_form.dest] <= '{ready: 1'b0, tag: tag_cnt, value: '0};
				tag_cnt <= tag_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== c16_math_lane.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "c16_defines.svh"

module c16_math_lane import c16_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  issue_pkt_t pkt,
	input  result_t    res_a,
	input  result_t    res_b,
	output logic       rs_full,
	output result_t    res
);

	logic [`C16_RS_SLOTS-1:0] occ;
	logic [`C16_RS_SLOTS-1:0] rdy;
	logic [`C16_RS_SLOTS-1:0] free_oh;
	logic [`C16_RS_SLOTS-1:0] sel_oh;
	logic [`C16_RS_SLOTS-1:0][`C16_RS_SLOTS-1:0] older;  // older[i][j] when i entered before j
	issue_pkt_t               slot [`C16_RS_SLOTS];
	issue_pkt_t               sel_pkt;
	logic                     res_vld;
	logic [`C16_TAG_W-1:0]    res_tag;
	logic [`C16_REG_W-1:0]    res_dest;
	logic [`C16_XLEN-1:0]     res_val;

	////////////////////////////////////////
	// Slot selection
	////////////////////////////////////////
	always_comb begin
		logic blocked;
		free_oh = '0;
		sel_oh = '0;
		for (int i = 0; i < `C16_RS_SLOTS; i++)
			rdy[i] = occ[i] && slot[i].a.ready && slot[i].b.ready;
		for (int i = 0; i < `C16_RS_SLOTS; i++) begin
			if (!occ[i] && free_oh == '0)
				free_oh[i] = 1'b1;
			blocked = 1'b0;
			for (int j = 0; j < `C16_RS_SLOTS; j++)
				if (rdy[j] && older[j][i])
					blocked = 1'b1;
			if (rdy[i] && !blocked)
				sel_oh[i] = 1'b1;  // Oldest ready entry
		end
		sel_pkt = '0;
		for (int i = 0; i < `C16_RS_SLOTS; i++)
			if (sel_oh[i])
				sel_pkt = slot[i];
	end

	assign rs_full = &occ;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			occ <= '0;
			older <= '0;
			res_vld <= 1'b0;
		end else begin
			res_vld <= |sel_oh;
			occ <= (occ & ~sel_oh) | (pkt.valid ? free_oh : '0);
			for (int i = 0; i < `C16_RS_SLOTS; i++)
				for (int j = 0; j < `C16_RS_SLOTS; j++)
					if (pkt.valid && free_oh[j] && i != j) begin
						older[i][j] <= 1'b1;
						older[j][i] <= 1'b0;
					end
		end
	end

	////////////////////////////////////////
	// Entries and add/subtract
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int i = 0; i < `C16_RS_SLOTS; i++) begin
			slot[i].a <= snoop(slot[i].a, res_a, res_b);
			slot[i].b <= snoop(slot[i].b, res_a, res_b);
			if (pkt.valid && free_oh[i])
				slot[i] <= pkt;
		end
		res_tag <= sel_pkt.tag;
		res_dest <= sel_pkt.dest;
		if (sel_pkt.op == ALU_SUB)
			res_val <= sel_pkt.a.value - sel_pkt.b.value;
		else
			res_val <= sel_pkt.a.value + sel_pkt.b.value;
	end

	assign res = '{valid: res_vld, tag: res_tag, dest: res_dest, value: res_val};

endmodule

`default_nettype wire

// ==== c16_reorder.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "c16_defines.svh"

module c16_reorder import c16_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  result_t alloc,
	input  result_t res0,
	input  result_t res1,
	output logic    rob_full,
	output logic [`C16_NREGS-1:0][`C16_XLEN-1:0] committed
);

	logic [`C16_ROB_DEPTH-1:0] busy;
	logic [`C16_ROB_DEPTH-1:0] done;
	logic [`C16_REG_W-1:0]     dest [`C16_ROB_DEPTH];
	logic [`C16_XLEN-1:0]      value [`C16_ROB_DEPTH];
	logic [`C16_TAG_W-1:0]     head;  // Oldest allocated tag
	logic                      commit;

	assign commit = busy[head] && done[head];
	assign rob_full = &busy;

	////////////////////////////////////////
	// Entry state and in-order commit
	////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= '0;
			done <= '0;
			head <= '0;
			committed <= '0;
		end else begin
			if (alloc.valid) begin
				busy[alloc.tag] <= 1'b1;
				done[alloc.tag] <= 1'b0;
			end
			// Both lanes may finish in one cycle
			if (res0.valid)
				done[res0.tag] <= 1'b1;
			if (res1.valid)
				done[res1.tag] <= 1'b1;
			if (commit) begin
				committed[dest[head]] <= value[head];
				busy[head] <= 1'b0;
				done[head] <= 1'b0;
				head <= head + 1'b1;
			end
		end
	end

	// Entry payload by tag
	always_ff @(posedge clk) begin
		if (alloc.valid)
			dest[alloc.tag] <= alloc.dest;
		if (res0.valid)
			value[res0.tag] <= res0.value;
		if (res1.valid)
			value[res1.tag] <= res1.value;
	end

endmodule

`default_nettype wire

// ==== c16_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "c16_defines.svh"

module c16_core import c16_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	issue_pkt_t lane0_pkt;
	issue_pkt_t lane1_pkt;
	result_t    res0;
	result_t    res1;
	result_t    alloc;
	logic       rs0_full;
	logic       rs1_full;
	logic       rob_full;
	logic [`C16_NREGS-1:0][`C16_XLEN-1:0] committed;

	c16_issue u_issue (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.res0      (res0),
		.res1      (res1),
		.rs0_full  (rs0_full),
		.rs1_full  (rs1_full),
		.rob_full  (rob_full),
		.committed (committed),
		.lane0_pkt (lane0_pkt),
		.lane1_pkt (lane1_pkt),
		.alloc     (alloc)
	);

	////////////////////////////////////////
	// Lanes snoop both buses
	////////////////////////////////////////
	c16_math_lane u_lane0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.pkt     (lane0_pkt),
		.res_a   (res0),
		.res_b   (res1),
		.rs_full (rs0_full),
		.res     (res0)
	);

	c16_math_lane u_lane1 (
		.clk     (clk),
		.arst_n  (arst_n),
		.pkt     (lane1_pkt),
		.res_a   (res1),
		.res_b   (res0),
		.rs_full (rs1_full),
		.res     (res1)
	);

	c16_reorder u_reorder (
		.clk       (clk),
		.arst_n    (arst_n),
		.alloc     (alloc),
		.res0      (res0),
		.res1      (res1),
		.rob_full  (rob_full),
		.committed (committed)
	);

endmodule

`default_nettype wire

// ==== c16_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "c16_defines.svh"

module c16_tb import c16_pkg::*; ();

	localparam int NTESTS = 6;
	localparam int SETTLE_CYCLES = 40;  // Drain time before the register reads

	logic                 clk;
	logic                 arst_n;
	wb_req_t              wb_req;
	wb_rsp_t              wb_rsp;

	logic [`C16_XLEN-1:0] prog_word [$];
	logic [2:0]           prog_adr [$];
	int                   test_first [NTESTS];
	int                   test_len [NTESTS];
	string                test_name [NTESTS];
	logic [`C16_XLEN-1:0] exp_regs [NTESTS][`C16_NREGS];
	logic [`C16_XLEN-1:0] model_regs [`C16_NREGS];

	int cycles = 0;
	int cycle_limit = 0;
	int test_errs = 0;
	int tests_ok = 0;
	int tests_bad = 0;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	c16_core i_c16_core (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Run stopped, cycle limit of %0d reached", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Instruction encoding and model
	////////////////////////////////////////
	function automatic logic [15:0] imm_word(input int opc, input int dest, input int src_a,
		input int imm);
		return {opc[4:0], dest[2:0], src_a[2:0], imm[4:0]};
	endfunction

	function automatic logic [15:0] reg_word(input int opc, input int dest, input int src_a,
		input int src_b);
		return {opc[4:0], dest[2:0], src_a[2:0], 2'b00, src_b[2:0]};
	endfunction

	function automatic void execute_word(input logic [2:0] adr, input logic [15:0] w);
		logic [15:0] imm;
		logic [15:0] va;
		logic [15:0] vb;
		imm = {{11{w[4]}}, w[4:0]};
		va = model_regs[w[7:5]];
		vb = model_regs[w[2:0]];
		if (adr != 3'd0)
			return;  // Only address 0 takes instructions
		case (w[15:11])
			`C16_OPC_ADDI: model_regs[w[10:8]] = va + imm;
			`C16_OPC_ADD:  model_regs[w[10:8]] = va + vb;
			`C16_OPC_SUBI: model_regs[w[10:8]] = va - imm;
			`C16_OPC_SUB:  model_regs[w[10:8]] = va - vb;
			default: ;
		endcase
	endfunction

	task automatic open_test(input int t, input string name);
		test_first[t] = prog_word.size();
		test_name[t] = name;
	endtask

	task automatic add_entry(input logic [15:0] w, input logic [2:0] adr);
		prog_word.push_back(w);
		prog_adr.push_back(adr);
	endtask

	// Run the model over the test's words and keep the register state
	task automatic close_test(input int t);
		test_len[t] = prog_word.size() - test_first[t];
		for (int k = test_first[t]; k < prog_word.size(); k++)
			execute_word(prog_adr[k], prog_word[k]);
		for (int r = 0; r < `C16_NREGS; r++)
			exp_regs[t][r] = model_regs[r];
	endtask

	task automatic build_table();
		for (int r = 0; r < `C16_NREGS; r++)
			model_regs[r] = '0;
		open_test(0, "reset_values");
		close_test(0);
		open_test(1, "imm_sign_ext");
		add_entry(imm_word(`C16_OPC_ADDI, 1, 0, -1), 3'd0);   // 0xffff
		add_entry(imm_word(`C16_OPC_SUBI, 2, 1, -16), 3'd0);  // Wraps to 0x000f
		add_entry(imm_word(`C16_OPC_ADDI, 3, 0, -16), 3'd0);
		add_entry(imm_word(`C16_OPC_SUBI, 4, 0, 15), 3'd0);
		add_entry(imm_word(`C16_OPC_ADDI, 5, 3, 15), 3'd0);
		for (int k = 0; k < 4; k++)
			add_entry(imm_word($urandom_range(1) ? `C16_OPC_SUBI : `C16_OPC_ADDI,
				$urandom_range(7), $urandom_range(7), $urandom_range(31)), 3'd0);
		close_test(1);
		// Each word reads the previous destination
		open_test(2, "reg_chain");
		add_entry(imm_word(`C16_OPC_ADDI, 1, 0, 13), 3'd0);
		add_entry(reg_word(`C16_OPC_ADD, 2, 1, 1), 3'd0);
		add_entry(reg_word(`C16_OPC_SUB, 3, 2, 5), 3'd0);
		add_entry(reg_word(`C16_OPC_ADD, 4, 3, 2), 3'd0);
		add_entry(reg_word(`C16_OPC_SUB, 5, 4, 1), 3'd0);
		add_entry(reg_word(`C16_OPC_ADD, 6, 5, 5), 3'd0);
		add_entry(reg_word(`C16_OPC_SUB, 7, 6, 3), 3'd0);
		add_entry(reg_word(`C16_OPC_ADD, 0, 7, 4), 3'd0);
		close_test(2);
		open_test(3, "rob_burst");
		for (int k = 0; k < 12; k++) begin
			case (k % 4)
				0: add_entry(imm_word(`C16_OPC_ADDI, 6, 6, 5), 3'd0);
				1: add_entry(reg_word(`C16_OPC_ADD, 6, 6, 2), 3'd0);
				2: add_entry(imm_word(`C16_OPC_SUBI, 6, 6, -3), 3'd0);
				default: add_entry(reg_word(`C16_OPC_SUB, 6, 6, 3), 3'd0);
			endcase
		end
		close_test(3);
		open_test(4, "ignored_words");
		add_entry(imm_word(4, 1, 0, 5), 3'd0);
		add_entry(imm_word(31, 2, 2, -1), 3'd0);
		add_entry(reg_word(17, 3, 1, 2), 3'd0);
		add_entry(imm_word(`C16_OPC_ADDI, 4, 0, 9), 3'd3);  // Valid word at a wrong address
		add_entry(reg_word(`C16_OPC_SUB, 5, 5, 6), 3'd7);
		add_entry(imm_word(`C16_OPC_SUBI, 7, 7, 1), 3'd1);
		close_test(4);
		open_test(5, "random_mix");
		for (int k = 0; k < 40; k++)
			add_entry({5'($urandom_range(3)), 11'($urandom_range(16'h07ff))}, 3'd0);
		close_test(5);
		cycle_limit = 1000 + 200 * prog_word.size();
	endtask

	////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////
	task automatic write_word(input logic [2:0] adr, input logic [15:0] dat);
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		do
			@(negedge clk);
		while (!wb_rsp.ack);  // Held low while the core is full
		wb_req = '0;
	endtask

	task automatic read_register(input int idx, output logic [15:0] val);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: idx[2:0], dat: '0};
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_rsp.ack);
		val = wb_rsp.dat;
		wb_req = '0;
		if (waited != 1) begin
			$display("Read of r%0d was acked after %0d cycles instead of 1", idx, waited);
			test_errs++;
		end
	endtask

	task automatic run_test(input int t);
		logic [15:0] got;
		test_errs = 0;
		for (int k = 0; k < test_len[t]; k++)
			write_word(prog_adr[test_first[t] + k], prog_word[test_first[t] + k]);
		repeat (SETTLE_CYCLES) @(negedge clk);
		for (int r = 0; r < `C16_NREGS; r++) begin
			read_register(r, got);
			if (got !== exp_regs[t][r]) begin
				$display("[ERROR] r%0d: expected 0x%04h, actual 0x%04h", r, exp_regs[t][r], got);
				test_errs++;
			end
		end
		if (test_errs == 0) begin
			$display("[PASS] %s", test_name[t]);
			tests_ok++;
		end else begin
			$display("[FAIL] %s with %0d errors", test_name[t], test_errs);
			tests_bad++;
		end
	endtask

	initial begin
		wb_req = '0;
		arst_n = 1'b0;
		void'($urandom(90));
		build_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int t = 0; t < NTESTS; t++)
			run_test(t);
		$display("Summary: %0d tests, %0d ok, %0d bad", NTESTS, tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
c16_pkg.sv
c16_issue.sv
c16_math_lane.sv
c16_reorder.sv
c16_core.sv
c16_tb.sv

// ==== Bender.yml ====
package:
  name: c16

sources:
  - include_dirs:
      - .
    files:
      - c16_pkg.sv
      - c16_issue.sv
      - c16_math_lane.sv
      - c16_reorder.sv
      - c16_core.sv
      - target: test
        files:
          - c16_tb.sv
